//--- compile.f
+incdir+include
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/echo_ctrl.sv
source/uart_echo_top.sv
testbench/uart_echo_checker.sv
testbench/tb_uart_echo.sv

//--- include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// clock cycles per serial bit
// 16 keeps simulation short, 48 gives 1 Mbaud from a 48 MHz clock
`define UART_CLKS_PER_BIT 16

// 1 adds an even parity bit after the data byte
`define UART_PARITY_EN 1

// cycles after reset before any frame is accepted
`define UART_STARTUP_CYCLES 2000

`endif

//--- source/echo_ctrl.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module echo_ctrl
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rx_frame_t  rx_frame,
    input  logic       rx_strobe,
    input  logic       tx_busy,
    output tx_req_t    tx_req,
    output logic       tx_start,
    output led_state_t leds
);

    localparam int STARTUP = `UART_STARTUP_CYCLES;
    localparam int ST_W = $clog2(STARTUP);
    localparam logic [ST_W-1:0] STARTUP_LAST = ST_W'(STARTUP - 1);

    // fsm encoding
    localparam logic [1:0] ST_STARTUP = 2'd0;
    localparam logic [1:0] ST_READY   = 2'd1;
    localparam logic [1:0] ST_PENDING = 2'd2;

    logic [1:0]      state;
    logic [ST_W-1:0] startup_cnt;
    logic            ready;
    logic            frame_good;
    logic            frame_bad;
    logic            err_q;
    tx_req_t         hold_q;

    // classify the frame in its strobe cycle
    assign frame_good = rx_strobe && !rx_frame.parity_error && !rx_frame.framing_error;
    assign frame_bad  = rx_strobe && (rx_frame.parity_error || rx_frame.framing_error);

    // anything past startup counts as ready, pending included
    assign ready = (state != ST_STARTUP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_STARTUP;
            startup_cnt <= '0;
            err_q       <= 1'b0;
        end else begin
            case (state)
                ST_STARTUP: begin
                    if (startup_cnt == STARTUP_LAST) begin
                        state <= ST_READY;
                    end else begin
                        startup_cnt <= startup_cnt + 1'b1;
                    end
                end
                ST_READY: begin
                    if (frame_good) begin
                        state <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    // tx_start fires this cycle when the line is free
                    if (!tx_busy) begin
                        state <= ST_READY;
                    end
                end
                default: state <= ST_STARTUP;
            endcase
            // sticky, only cleared by reset
            // bad frames before startup are ignored
            if (ready && frame_bad) begin
                err_q <= 1'b1;
            end
        end
    end

    // holding register, loaded in the strobe cycle
    always_ff @(posedge clk) begin
        if (state == ST_READY && frame_good) begin
            hold_q.data <= rx_frame.data;
        end
    end

    assign tx_req   = hold_q;
    assign tx_start = (state == ST_PENDING) && !tx_busy;

    assign leds.red   = err_q;
    assign leds.green = ready;
    assign leds.blue  = tx_busy;

    // same baud both ways, held byte leaves before the next frame lands
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        (state == ST_PENDING) |-> !frame_good)
        else $error("echo_ctrl: good frame arrived while a byte was still held");

endmodule

//--- source/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst,
    // serial in from the host
    input  logic rx,
    // serial echo back to the host
    output logic tx,
    // board leds, active low
    output logic led_red,
    output logic led_green,
    output logic led_blue
);

    rx_frame_t  rx_frame;
    logic       rx_strobe;
    tx_req_t    tx_req;
    logic       tx_start;
    logic       tx_busy;
    led_state_t leds;

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_frame  (rx_frame),
        .rx_strobe (rx_strobe)
    );

    // startup, holding byte and status
    echo_ctrl u_echo_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rx_frame  (rx_frame),
        .rx_strobe (rx_strobe),
        .tx_busy   (tx_busy),
        .tx_req    (tx_req),
        .tx_start  (tx_start),
        .leds      (leds)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_req   (tx_req),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // pins sink current, so lit means low
    assign led_red   = ~leds.red;
    assign led_green = ~leds.green;
    assign led_blue  = ~leds.blue;

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    // one received frame, as handed from receiver to controller
    typedef struct packed {
        // payload byte, bit 0 came first on the line
        logic [7:0] data;
        // parity bit did not match even parity of data
        logic       parity_error;
        // stop bit sampled low
        logic       framing_error;
    } rx_frame_t;

    // byte queued for the transmitter
    typedef struct packed {
        logic [7:0] data;
    } tx_req_t;

    // logical led state, 1 means lit
    // pins are active low, inverted at top only
    typedef struct packed {
        // sticky error
        logic red;
        // ready for traffic
        logic green;
        // transmit in progress
        logic blue;
    } led_state_t;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx,
    output rx_frame_t rx_frame,
    output logic      rx_strobe
);

    localparam int CLKS = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS - 1);
    // half a bit period, start bit is confirmed here
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS / 2 - 1);
    localparam bit PAR_EN = (`UART_PARITY_EN != 0);

    // fsm encoding
    localparam logic [2:0] RX_IDLE      = 3'd0;
    localparam logic [2:0] RX_START     = 3'd1;
    localparam logic [2:0] RX_DATA      = 3'd2;
    localparam logic [2:0] RX_PARITY    = 3'd3;
    localparam logic [2:0] RX_STOP      = 3'd4;
    localparam logic [2:0] RX_WAIT_IDLE = 3'd5;

    logic [2:0]       state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             start_edge;
    logic             bit_tick;
    logic [7:0]       shift_q;
    logic             par_bit;
    rx_frame_t        frame_q;
    logic             strobe_q;

    // two flop synchronizer, plus one more for edge detect
    // line idles high, so reset to 1
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // falling edge opens a frame
    assign start_edge = rx_prev & ~rx_sync;
    // mid-bit sample point for data, parity and stop
    assign bit_tick = (clk_cnt == LAST_CNT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch shorter than half a bit, back to hunting
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= PAR_EN ? RX_PARITY : RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_PARITY: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        state   <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        clk_cnt  <= '0;
                        strobe_q <= 1'b1;
                        // low stop bit, line may sit low for a while
                        state    <= rx_sync ? RX_IDLE : RX_WAIT_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_WAIT_IDLE: begin
                    if (rx_sync) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // datapath, lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_tick) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == RX_PARITY && bit_tick) begin
            par_bit <= rx_sync;
        end
        // frame is latched with the strobe and held until the next one
        if (state == RX_STOP && bit_tick) begin
            frame_q.data          <= shift_q;
            frame_q.parity_error  <= PAR_EN && (par_bit != ^shift_q);
            frame_q.framing_error <= ~rx_sync;
        end
    end

    assign rx_frame  = frame_q;
    assign rx_strobe = strobe_q;

    // one strobe per frame, frames are many cycles apart
    a_single_strobe: assert property (@(posedge clk) disable iff (rst)
        rx_strobe |=> !rx_strobe)
        else $error("uart_rx: rx_strobe high on consecutive cycles");

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  tx_req_t tx_req,
    input  logic    tx_start,
    output logic    tx,
    output logic    tx_busy
);

    localparam int CLKS = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS - 1);
    localparam bit PAR_EN = (`UART_PARITY_EN != 0);
    // start + 8 data + optional parity + stop
    localparam int NBITS = 10 + int'(PAR_EN);
    localparam int IDX_W = $clog2(NBITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(NBITS - 1);

    logic [NBITS-1:0] frame_bits;
    // bits still to go out after the start bit
    logic [NBITS-2:0] shift_q;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    logic             busy_q;
    logic             tx_q;
    logic             bit_tick;

    // whole frame with bit 0 leaving first
    if (PAR_EN) begin : g_parity
        assign frame_bits = {1'b1, ^tx_req.data, tx_req.data, 1'b0};
    end else begin : g_no_parity
        assign frame_bits = {1'b1, tx_req.data, 1'b0};
    end

    // end of the current bit period
    assign bit_tick = busy_q && (clk_cnt == LAST_CNT);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            tx_q    <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (tx_start) begin
            // start bit goes out right away
            busy_q  <= 1'b1;
            tx_q    <= frame_bits[0];
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (busy_q) begin
            if (bit_tick) begin
                clk_cnt <= '0;
                if (bit_idx == LAST_BIT) begin
                    // end of the stop bit
                    busy_q <= 1'b0;
                    tx_q   <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    tx_q    <= shift_q[0];
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // shifter refills with ones so the line idles high
    always_ff @(posedge clk) begin
        if (tx_start) begin
            shift_q <= frame_bits[NBITS-1:1];
        end else if (bit_tick) begin
            shift_q <= {1'b1, shift_q[NBITS-2:1]};
        end
    end

    assign tx      = tx_q;
    assign tx_busy = busy_q;

    // controller must wait for the previous frame to finish
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while a frame is in progress");

endmodule

//--- testbench/tb_uart_echo.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_echo;

    localparam int CLKS = `UART_CLKS_PER_BIT;
    localparam int STARTUP = `UART_STARTUP_CYCLES;
    localparam bit PAR_EN = (`UART_PARITY_EN != 0);
    localparam int NUM_FRAMES = 60;
    // sent right after reset and before ready
    localparam int EARLY_FRAMES = 3;
    // start, data, parity, stop plus the longest idle gap
    localparam int FRAME_MAX = (10 + int'(PAR_EN) + 3) * CLKS;
    localparam int TIMEOUT_CYCLES = 64 * FRAME_MAX * 2 + STARTUP;

    bit          clk;
    logic        rst;
    logic        rx;
    logic        tx;
    logic        led_red;
    logic        led_green;
    logic        led_blue;
    int          checker_errors;
    int          pending;
    int          echoed;
    int          tb_errors;
    int          sent;
    int          cycle;
    int          since_reset;
    logic [31:0] lfsr;

    uart_echo_top DUT (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

    // watches the pins only
    uart_echo_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .tx            (tx),
        .led_red       (led_red),
        .led_green     (led_green),
        .led_blue      (led_blue),
        .error_count   (checker_errors),
        .pending_count (pending),
        .echo_count    (echoed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // starts and ends on a negedge
    task automatic drive_bit(input logic b);
        rx = b;
        repeat (CLKS) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input bit bad_par,
                              input bit bad_stop, input int gap);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (PAR_EN) begin
            drive_bit(^data ^ bad_par);
        end
        drive_bit(!bad_stop);
        repeat (gap) drive_bit(1'b1);
    endtask

    // timeout and cycle counts
    always @(posedge clk) begin
        cycle++;
        since_reset = rst ? 0 : since_reset + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin : stimulus
        logic [7:0] data;
        bit         bad_par;
        bit         bad_stop;
        int         gap;
        int         wait_cnt;
        rst         = 1'b1;
        rx          = 1'b1;
        lfsr        = 32'h69c3_a2d3;
        tb_errors   = 0;
        sent        = 0;
        cycle       = 0;
        since_reset = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_FRAMES; n++) begin
            if (n == EARLY_FRAMES) begin
                // main run starts well clear of ready
                while (since_reset < STARTUP + 200) begin
                    @(negedge clk);
                end
            end
            data     = take_bits(8);
            bad_par  = PAR_EN && (take_bits(3) == 0);
            bad_stop = (take_bits(4) == 0);
            gap      = take_bits(2);
            // one clean and one bad frame land before ready
            if (n == 0) begin
                bad_par  = 1'b0;
                bad_stop = 1'b0;
            end
            if (n == 1) begin
                bad_par = PAR_EN;
            end
            // at least one of each error kind after ready
            if (n == 10) begin
                bad_par = PAR_EN;
            end
            if (n == 20) begin
                bad_stop = 1'b1;
            end
            // receiver needs an idle line after a low stop bit
            if (bad_stop && gap == 0) begin
                gap = 1;
            end
            send_frame(data, bad_par, bad_stop, gap);
            sent++;
        end
        // bounded wait for the last echoes
        wait_cnt = 0;
        while (pending != 0 && wait_cnt < 4 * FRAME_MAX) begin
            @(negedge clk);
            wait_cnt++;
        end
        // quiet line to catch stray tx frames
        repeat (2 * FRAME_MAX) @(negedge clk);
        if (pending != 0) begin
            $display("%0d expected echo bytes never came back on tx", pending);
            tb_errors++;
        end
        $display("summary: %0d frames sent, %0d bytes echoed, %0d checker errors, %0d tb errors",
                 sent, echoed, checker_errors, tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- testbench/uart_echo_checker.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_echo_checker
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic tx,
    input  logic led_red,
    input  logic led_green,
    input  logic led_blue,
    output int   error_count,
    output int   pending_count,
    output int   echo_count
);

    localparam int CLKS = `UART_CLKS_PER_BIT;
    localparam int STARTUP = `UART_STARTUP_CYCLES;
    localparam bit PAR_EN = (`UART_PARITY_EN != 0);

    // bytes still owed on tx, oldest first
    logic [7:0] expected_q[$];
    // cycles since reset release
    int         cyc;
    // model of the sticky red led
    bit         model_err;
    int         err_cycle;
    // negedges with tx idle and no frame running
    int         tx_idle;

    initial begin
        error_count   = 0;
        pending_count = 0;
        echo_count    = 0;
        cyc           = 0;
        model_err     = 1'b0;
        err_cycle     = 0;
        tx_idle       = 0;
    end

    task automatic log_mismatch(input string msg);
        error_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic count_failure(input string msg);
        error_count++;
        $display("%s, at %0t", msg, $time);
    endtask

    task automatic expect_blue_lit();
        if (led_blue !== 1'b0) begin
            count_failure("led_blue is not lit in the middle of a tx frame");
        end
    endtask

    // echo rules applied to one decoded rx frame
    task automatic apply_echo_rules(input rx_frame_t frame);
        if (cyc < STARTUP) begin
            // not ready yet, frame dropped and no led
        end else if (frame.parity_error || frame.framing_error) begin
            if (!model_err) begin
                model_err = 1'b1;
                err_cycle = cyc;
            end
        end else begin
            expected_q.push_back(frame.data);
            pending_count = expected_q.size();
        end
    endtask

    // cycle count, reset state and led levels
    always @(negedge clk) begin
        if (rst) begin
            cyc = 0;
            if (tx !== 1'b1 || led_red !== 1'b1 || led_green !== 1'b1 || led_blue !== 1'b1) begin
                count_failure("tx or an led pin is not high during reset");
            end
        end else begin
            cyc++;
            if (cyc < STARTUP && tx !== 1'b1) begin
                count_failure("tx left idle before the startup interval ended");
            end
            // once per bit period is plenty for slow status pins
            if (cyc % CLKS == 0) begin
                if (cyc < STARTUP - 4 && led_green !== 1'b1) begin
                    count_failure("led_green lit before the startup interval ended");
                end
                if (cyc > STARTUP + 4 && led_green !== 1'b0) begin
                    count_failure("led_green not lit after the startup interval");
                end
                if (!model_err && led_red !== 1'b1) begin
                    count_failure("led_red lit with no error frame received while ready");
                end
                // strobe lags the stop bit sample by a few cycles
                if (model_err && cyc > err_cycle + 8 && led_red !== 1'b0) begin
                    count_failure("led_red not lit after an error frame");
                end
            end
        end
    end

    // rx decode, input changes on negedge so sample on posedge
    initial begin : rx_decode
        rx_frame_t frame;
        logic      par;
        forever begin
            @(posedge clk);
            if (!rst && rx === 1'b0) begin
                // move to the middle of the start bit
                repeat (CLKS / 2 - 1) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(posedge clk);
                    frame.data[i] = rx;
                end
                par = 1'b0;
                if (PAR_EN) begin
                    repeat (CLKS) @(posedge clk);
                    par = rx;
                end
                repeat (CLKS) @(posedge clk);
                frame.framing_error = ~rx;
                frame.parity_error  = PAR_EN && (par != ^frame.data);
                apply_echo_rules(frame);
                // low stop bit, line must come back up first
                while (rx !== 1'b1) begin
                    @(posedge clk);
                end
            end
        end
    end

    // tx decode, DUT outputs settle after posedge so sample on negedge
    initial begin : tx_decode
        logic [7:0] data;
        logic [7:0] want;
        logic       par;
        logic       start_bit;
        logic       stop_bit;
        forever begin
            @(negedge clk);
            if (rst) begin
                tx_idle = 0;
            end else if (tx === 1'b0) begin
                tx_idle = 0;
                repeat (CLKS / 2 - 1) @(negedge clk);
                start_bit = tx;
                expect_blue_lit();
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    data[i] = tx;
                    expect_blue_lit();
                end
                par = ^data;
                if (PAR_EN) begin
                    repeat (CLKS) @(negedge clk);
                    par = tx;
                    expect_blue_lit();
                end
                repeat (CLKS) @(negedge clk);
                stop_bit = tx;
                expect_blue_lit();
                if (start_bit !== 1'b0) begin
                    count_failure("tx start bit did not stay low to mid-bit");
                end
                if (par !== ^data) begin
                    count_failure("tx frame has a wrong parity bit");
                end
                if (stop_bit !== 1'b1) begin
                    count_failure("tx frame has a low stop bit");
                end
                if (expected_q.size() == 0) begin
                    log_mismatch($sformatf("unexpected echo byte 0x%02h on tx", data));
                end else begin
                    want = expected_q.pop_front();
                    pending_count = expected_q.size();
                    echo_count++;
                    if (data !== want) begin
                        log_mismatch($sformatf("echo byte 0x%02h, expected 0x%02h", data, want));
                    end
                end
            end else begin
                tx_idle++;
                // busy ends half a bit after the stop sample
                if (tx_idle >= CLKS && led_blue !== 1'b1) begin
                    count_failure("led_blue lit while tx is idle");
                end
            end
        end
    end

endmodule
